/* Bender.yml */
package:
  name: hyper_rx

sources:
  - hdl/hyper_phy_pkg.sv
  - hdl/hyper_axi_pkg.sv
  - hdl/hyper_rx_ifs.sv
  - hdl/hyper_rx_burst_queue.sv
  - hdl/hyper_rx_upsizer.sv
  - hdl/hyper_rx_r_slice.sv
  - hdl/hyper_rx_top.sv
  - target: test
    files:
      - verif/tb_hyper_rx_top.sv

/* hdl/hyper_axi_pkg.sv */
// AXI-side constants and types of the HyperBus read path
// beat data, size, length, offset, burst address and response

`default_nettype none

package hyper_axi_pkg;

  localparam int unsigned AxiDataWidth = 64;
  localparam int unsigned AxiBytes     = AxiDataWidth / 8;

  typedef logic [AxiDataWidth-1:0]     axi_data_t;
  typedef logic [$clog2(AxiBytes)-1:0] axi_offset_t;

  // log2 of bytes per beat, 0 to 3 only
  typedef logic [2:0] axi_size_t;

  // beats minus one
  typedef logic [3:0] axi_len_t;

  // byte address inside a burst, covers 16 beats of 8 bytes
  typedef logic [7:0] burst_addr_t;

  typedef logic [1:0] axi_resp_t;

  localparam axi_resp_t RespOkay   = 2'b00;
  localparam axi_resp_t RespSlvErr = 2'b10;

endpackage

`default_nettype wire

/* hdl/hyper_phy_pkg.sv */
// PHY-side constants and types of the HyperBus read path
// one PHY delivering 16-bit words

`default_nettype none

package hyper_phy_pkg;

  // bits per PHY word
  localparam int unsigned PhyWidth = 16;

  // bytes per PHY word
  localparam int unsigned PhyBytes = PhyWidth / 8;

  typedef logic [PhyWidth-1:0] phy_data_t;

endpackage

`default_nettype wire

/* hdl/hyper_rx_burst_queue.sv */
// descriptor FIFO for accepted read requests
// end address of each burst is computed on entry

`timescale 1ns/1ps
`default_nettype none

module hyper_rx_burst_queue import hyper_axi_pkg::*; #(
  parameter int unsigned QueueDepth = 2
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      req_valid_i,
  output logic                      req_ready_o,
  input  axi_offset_t               req_offset_i,
  input  axi_size_t                 req_size_i,
  input  axi_len_t                  req_len_i,
  hyper_rx_burst_if.producer        burst_o
);

  localparam int unsigned PtrWidth = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
  localparam int unsigned CntWidth = $clog2(QueueDepth + 1);

  axi_offset_t offset_mem [QueueDepth];
  axi_size_t   size_mem   [QueueDepth];
  burst_addr_t end_mem    [QueueDepth];

  logic [PtrWidth-1:0] wr_ptr_q, rd_ptr_q;
  logic [CntWidth-1:0] count_q;
  logic                push, pop, full;
  burst_addr_t         beat_bytes, base_addr, span;

  function automatic logic [PtrWidth-1:0] ptr_inc(input logic [PtrWidth-1:0] ptr);
    return (ptr == PtrWidth'(QueueDepth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // start aligned down to size, plus all beats
  assign beat_bytes = burst_addr_t'(1) << req_size_i;
  assign base_addr  = burst_addr_t'(req_offset_i) & ~(beat_bytes - 1'b1);
  assign span       = (burst_addr_t'(req_len_i) + 1'b1) << req_size_i;

  assign full        = (count_q == CntWidth'(QueueDepth));
  assign req_ready_o = !full;
  assign push        = req_valid_i && req_ready_o;
  assign pop         = burst_o.valid && burst_o.ready;

  assign burst_o.valid    = (count_q != '0);
  assign burst_o.offset   = offset_mem[rd_ptr_q];
  assign burst_o.size     = size_mem[rd_ptr_q];
  assign burst_o.end_addr = end_mem[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push) begin
      offset_mem[wr_ptr_q] <= req_offset_i;
      size_mem[wr_ptr_q]   <= req_size_i;
      end_mem[wr_ptr_q]    <= base_addr + span;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // pointers meet only on an empty or full queue
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (wr_ptr_q == rd_ptr_q) == ((count_q == '0) || full));

  // descriptor held until the upsizer takes it
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    burst_o.valid && !burst_o.ready |=> burst_o.valid &&
      $stable({burst_o.offset, burst_o.size, burst_o.end_addr}));

endmodule

`default_nettype wire

/* hdl/hyper_rx_ifs.sv */
// burst descriptor interface between queue and upsizer
// packed beat interface between upsizer and R slice

`timescale 1ns/1ps
`default_nettype none

interface hyper_rx_burst_if import hyper_axi_pkg::*; ();

  logic        valid;
  logic        ready;
  axi_offset_t offset;
  axi_size_t   size;
  // first address past the final beat
  burst_addr_t end_addr;

  modport producer (
    output valid, offset, size, end_addr,
    input  ready
  );

  modport consumer (
    input  valid, offset, size, end_addr,
    output ready
  );

endinterface

interface hyper_rx_word_if import hyper_axi_pkg::*; ();

  logic      valid;
  logic      ready;
  axi_data_t data;
  axi_resp_t resp;
  logic      last;

  modport producer (
    output valid, data, resp, last,
    input  ready
  );

  modport consumer (
    input  valid, data, resp, last,
    output ready
  );

endinterface

`default_nettype wire

/* hdl/hyper_rx_r_slice.sv */
// R channel output stage with main and skid registers
// upstream ready comes straight from a flop

`timescale 1ns/1ps
`default_nettype none

module hyper_rx_r_slice import hyper_axi_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_ni,
  hyper_rx_word_if.consumer word_i,
  output logic              r_valid_o,
  input  logic              r_ready_i,
  output axi_data_t         r_data_o,
  output axi_resp_t         r_resp_o,
  output logic              r_last_o
);

  logic      valid_q, skid_valid_q;
  axi_data_t data_q, skid_data_q;
  axi_resp_t resp_q, skid_resp_q;
  logic      last_q, skid_last_q;
  logic      word_hs, main_free;

  assign word_i.ready = !skid_valid_q;
  assign word_hs      = word_i.valid && word_i.ready;
  // main register empty or being read this cycle
  assign main_free    = !valid_q || r_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q      <= 1'b0;
      skid_valid_q <= 1'b0;
    end else if (main_free) begin
      valid_q      <= skid_valid_q || word_hs;
      skid_valid_q <= 1'b0;
    end else if (word_hs) begin
      skid_valid_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (main_free) begin
      if (skid_valid_q) begin
        data_q <= skid_data_q;
        resp_q <= skid_resp_q;
        last_q <= skid_last_q;
      end else if (word_hs) begin
        data_q <= word_i.data;
        resp_q <= word_i.resp;
        last_q <= word_i.last;
      end
    end else if (word_hs) begin
      skid_data_q <= word_i.data;
      skid_resp_q <= word_i.resp;
      skid_last_q <= word_i.last;
    end
  end

  assign r_valid_o = valid_q;
  assign r_data_o  = data_q;
  assign r_resp_o  = resp_q;
  assign r_last_o  = last_q;

  // beat held unchanged under back-pressure
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    r_valid_o && !r_ready_i |=> r_valid_o && $stable({r_data_o, r_resp_o, r_last_o}));

endmodule

`default_nettype wire

/* hdl/hyper_rx_top.sv */
// read-data return path of the HyperBus controller
// descriptor queue, upsizer and R slice in a chain

`timescale 1ns/1ps
`default_nettype none

module hyper_rx_top import hyper_phy_pkg::*, hyper_axi_pkg::*; #(
  parameter int unsigned QueueDepth = 2
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  // read requests
  input  logic        req_valid_i,
  output logic        req_ready_o,
  input  axi_offset_t req_offset_i,
  input  axi_size_t   req_size_i,
  input  axi_len_t    req_len_i,
  // PHY word stream
  input  logic        phy_valid_i,
  output logic        phy_ready_o,
  input  phy_data_t   phy_data_i,
  input  logic        phy_last_i,
  input  logic        phy_error_i,
  // AXI R channel
  output logic        r_valid_o,
  input  logic        r_ready_i,
  output axi_data_t   r_data_o,
  output axi_resp_t   r_resp_o,
  output logic        r_last_o
);

  hyper_rx_burst_if burst_if ();
  hyper_rx_word_if  word_if ();

  hyper_rx_burst_queue #(
    .QueueDepth (QueueDepth)
  ) u_burst_queue (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .req_offset_i (req_offset_i),
    .req_size_i   (req_size_i),
    .req_len_i    (req_len_i),
    .burst_o      (burst_if.producer)
  );

  hyper_rx_upsizer u_upsizer (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .burst_i     (burst_if.consumer),
    .phy_valid_i (phy_valid_i),
    .phy_ready_o (phy_ready_o),
    .phy_data_i  (phy_data_i),
    .phy_last_i  (phy_last_i),
    .phy_error_i (phy_error_i),
    .word_o      (word_if.producer)
  );

  hyper_rx_r_slice u_r_slice (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .word_i    (word_if.consumer),
    .r_valid_o (r_valid_o),
    .r_ready_i (r_ready_i),
    .r_data_o  (r_data_o),
    .r_resp_o  (r_resp_o),
    .r_last_o  (r_last_o)
  );

endmodule

`default_nettype wire

/* hdl/hyper_rx_upsizer.sv */
// packs 16-bit PHY words into 64-bit AXI beats
// narrow sizes and unaligned starts follow AXI narrow transfer rules

`timescale 1ns/1ps
`default_nettype none

module hyper_rx_upsizer import hyper_phy_pkg::*, hyper_axi_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_ni,
  hyper_rx_burst_if.consumer burst_i,
  input  logic               phy_valid_i,
  output logic               phy_ready_o,
  input  phy_data_t          phy_data_i,
  input  logic               phy_last_i,
  input  logic               phy_error_i,
  hyper_rx_word_if.producer  word_o
);

  localparam int unsigned NumLanes  = AxiBytes / PhyBytes;
  localparam int unsigned LaneWidth = $clog2(NumLanes);
  localparam int unsigned LaneLsb   = $clog2(PhyBytes);

  // Drain offers a beat that is already in the buffer, no PHY word needed
  typedef enum logic [1:0] {
    Idle,
    Collect,
    Emit,
    Drain
  } upsizer_state_e;

  upsizer_state_e state_d, state_q;
  burst_addr_t    beat_addr_d, beat_addr_q;
  burst_addr_t    cnt_d, cnt_q;
  burst_addr_t    end_d, end_q;
  axi_size_t      size_d, size_q;
  logic           err_d, err_q;
  axi_data_t      buf_d, buf_q;

  burst_addr_t          size_bytes, next_addr, cnt_inc;
  logic [LaneWidth-1:0] lane;
  logic                 phy_hs, word_hs;

  assign size_bytes = burst_addr_t'(1) << size_q;
  // first address past the current beat
  assign next_addr  = (beat_addr_q & ~(size_bytes - 1'b1)) + size_bytes;
  assign cnt_inc    = cnt_q + burst_addr_t'(PhyBytes);
  // buffer wraps every AXI word
  assign lane       = cnt_q[LaneLsb +: LaneWidth];

  assign phy_ready_o   = (state_q == Collect);
  assign burst_i.ready = (state_q == Idle);
  assign phy_hs        = phy_valid_i && phy_ready_o;
  assign word_hs       = word_o.valid && word_o.ready;

  assign word_o.valid = (state_q == Emit) || (state_q == Drain);
  assign word_o.data  = buf_q;
  assign word_o.resp  = err_q ? RespSlvErr : RespOkay;
  assign word_o.last  = (next_addr == end_q);

  always_comb begin
    state_d     = state_q;
    beat_addr_d = beat_addr_q;
    cnt_d       = cnt_q;
    end_d       = end_q;
    size_d      = size_q;
    err_d       = err_q;
    buf_d       = buf_q;
    case (state_q)
      Idle: begin
        if (burst_i.valid) begin
          beat_addr_d = burst_addr_t'(burst_i.offset);
          cnt_d       = burst_addr_t'(burst_i.offset) & ~burst_addr_t'(PhyBytes - 1);
          end_d       = burst_i.end_addr;
          size_d      = burst_i.size;
          err_d       = 1'b0;
          state_d     = Collect;
        end
      end
      Collect: begin
        if (phy_hs) begin
          buf_d[lane*PhyWidth +: PhyWidth] = phy_data_i;
          cnt_d = cnt_inc;
          err_d = err_q | phy_error_i;
          if (cnt_inc >= next_addr) begin
            state_d = Emit;
          end
        end
      end
      Emit, Drain: begin
        if (word_hs) begin
          beat_addr_d = next_addr;
          if (word_o.last) begin
            state_d = Idle;
          end else if (cnt_q >= next_addr + size_bytes) begin
            // byte beats share a word, so the error flag carries over
            state_d = Drain;
          end else begin
            err_d   = 1'b0;
            state_d = Collect;
          end
        end
      end
      default: state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= Idle;
      beat_addr_q <= '0;
      cnt_q       <= '0;
      end_q       <= '0;
      size_q      <= '0;
      err_q       <= 1'b0;
    end else begin
      state_q     <= state_d;
      beat_addr_q <= beat_addr_d;
      cnt_q       <= cnt_d;
      end_q       <= end_d;
      size_q      <= size_d;
      err_q       <= err_d;
    end
  end

  always_ff @(posedge clk_i) begin
    buf_q <= buf_d;
  end

  // no PHY word once the whole burst is collected
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    phy_hs |-> cnt_q < end_q);

  // last marks exactly the word that completes the final beat
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    phy_hs |-> phy_last_i == (cnt_inc >= end_q));

endmodule

`default_nettype wire

/* hyper_rx_top.f */
hdl/hyper_phy_pkg.sv
hdl/hyper_axi_pkg.sv
hdl/hyper_rx_ifs.sv
hdl/hyper_rx_burst_queue.sv
hdl/hyper_rx_upsizer.sv
hdl/hyper_rx_r_slice.sv
hdl/hyper_rx_top.sv
verif/tb_hyper_rx_top.sv

/* verif/tb_hyper_rx_top.sv */
// testbench for the HyperBus read-data return path
// random requests, PHY words and R back-pressure checked against a byte model

`timescale 1ns/1ps
`default_nettype none

module tb_hyper_rx_top import hyper_phy_pkg::*, hyper_axi_pkg::*; ();

  localparam int NumReqs       = 40;
  localparam int TimeoutCycles = NumReqs * 64 + 200;

  logic        clk_i;
  logic        rst_ni;
  logic        req_valid_i;
  logic        req_ready_o;
  axi_offset_t req_offset_i;
  axi_size_t   req_size_i;
  axi_len_t    req_len_i;
  logic        phy_valid_i;
  logic        phy_ready_o;
  phy_data_t   phy_data_i;
  logic        phy_last_i;
  logic        phy_error_i;
  logic        r_valid_o;
  logic        r_ready_i;
  axi_data_t   r_data_o;
  axi_resp_t   r_resp_o;
  logic        r_last_o;

  integer seed;

  // request list and the bytes the PHY returns for each burst
  axi_offset_t req_offset [NumReqs];
  axi_size_t   req_size   [NumReqs];
  axi_len_t    req_len    [NumReqs];
  logic [7:0]  mem_byte   [NumReqs][256];
  logic        mem_err    [NumReqs][256];

  int          req_idx, phy_req, phy_word, chk_req, chk_beat, cycles;
  burst_addr_t chk_addr;
  logic        req_take, phy_take, queue_filled, running;

  hyper_rx_top u_hyper_rx_top (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .req_offset_i (req_offset_i),
    .req_size_i   (req_size_i),
    .req_len_i    (req_len_i),
    .phy_valid_i  (phy_valid_i),
    .phy_ready_o  (phy_ready_o),
    .phy_data_i   (phy_data_i),
    .phy_last_i   (phy_last_i),
    .phy_error_i  (phy_error_i),
    .r_valid_o    (r_valid_o),
    .r_ready_i    (r_ready_i),
    .r_data_o     (r_data_o),
    .r_resp_o     (r_resp_o),
    .r_last_o     (r_last_o)
  );

  always #10 clk_i = ~clk_i;

  // PHY stream starts at the offset aligned down to a word
  function automatic burst_addr_t start_addr(int n);
    return burst_addr_t'(req_offset[n]) & 8'hfe;
  endfunction

  function automatic burst_addr_t end_addr(int n);
    burst_addr_t sz;
    sz = burst_addr_t'(1) << req_size[n];
    return (burst_addr_t'(req_offset[n]) & ~(sz - 8'd1)) +
      (burst_addr_t'(req_len[n]) + 8'd1) * sz;
  endfunction

  function automatic int word_count(int n);
    return (int'(end_addr(n)) - int'(start_addr(n)) + 1) / 2;
  endfunction

  task automatic build_model();
    int          n, k;
    burst_addr_t a;
    logic        err;
    for (n = 0; n < NumReqs; n++) begin
      if (n < 2) begin
        // full-width bursts first
        req_offset[n] = '0;
        req_size[n]   = 3'd3;
        req_len[n]    = (n == 0) ? 4'd3 : 4'd15;
      end else begin
        req_offset[n] = axi_offset_t'($random(seed));
        req_size[n]   = axi_size_t'($random(seed) & 3);
        req_len[n]    = axi_len_t'($random(seed));
      end
      a = start_addr(n);
      for (k = 0; k < word_count(n); k++) begin
        err = (($random(seed) & 15) == 0);
        {mem_byte[n][a + 8'd1], mem_byte[n][a]} = 16'($random(seed));
        mem_err[n][a]        = err;
        mem_err[n][a + 8'd1] = err;
        a = a + 8'd2;
      end
    end
  endtask

  task automatic stop_on_error();
    $display("Testbench failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_data(axi_data_t got, axi_data_t exp, axi_data_t mask);
    if ((got & mask) !== (exp & mask)) begin
      $display("[FAIL] %0t r_data_o got %h expected %h mask %h", $time, got, exp, mask);
      stop_on_error();
    end
  endtask

  task automatic check_resp(axi_resp_t got, axi_resp_t exp);
    if (got !== exp) begin
      $display("[FAIL] %0t r_resp_o got %0d expected %0d", $time, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_last(logic got, logic exp);
    if (got !== exp) begin
      $display("[FAIL] %0t r_last_o got %b expected %b", $time, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  // expected lanes, mask and response of the beat at chk_addr
  task automatic check_beat();
    burst_addr_t sz, nxt, x;
    axi_data_t   exp_data, mask;
    axi_resp_t   exp_resp;
    if (chk_req >= NumReqs) begin
      $display("ERROR: DUT returned a beat after all bursts were complete");
      stop_on_error();
    end else begin
      sz       = burst_addr_t'(1) << req_size[chk_req];
      nxt      = (chk_addr & ~(sz - 8'd1)) + sz;
      exp_data = '0;
      mask     = '0;
      exp_resp = RespOkay;
      for (x = chk_addr; x != nxt; x++) begin
        exp_data[x[2:0]*8 +: 8] = mem_byte[chk_req][x];
        mask[x[2:0]*8 +: 8]     = 8'hff;
        if (mem_err[chk_req][x]) begin
          exp_resp = RespSlvErr;
        end
      end
      check_data(r_data_o, exp_data, mask);
      check_resp(r_resp_o, exp_resp);
      check_last(r_last_o, chk_beat == int'(req_len[chk_req]));
      chk_addr = nxt;
      if (chk_beat == int'(req_len[chk_req])) begin
        chk_req++;
        chk_beat = 0;
        if (chk_req < NumReqs) begin
          chk_addr = burst_addr_t'(req_offset[chk_req]);
        end
      end else begin
        chk_beat++;
      end
    end
  endtask

  task automatic drive_request();
    if (req_take) begin
      req_idx++;
    end
    if (req_idx < NumReqs) begin
      if (req_take || !req_valid_i) begin
        req_valid_i = ($random(seed) & 7) != 0;
      end
      req_offset_i = req_offset[req_idx];
      req_size_i   = req_size[req_idx];
      req_len_i    = req_len[req_idx];
    end else begin
      req_valid_i = 1'b0;
    end
    req_take = req_valid_i && req_ready_o;
    if (req_valid_i && !req_ready_o) begin
      queue_filled = 1'b1;
    end
  endtask

  task automatic drive_phy();
    burst_addr_t a;
    if (phy_take) begin
      phy_word++;
      if (phy_word == word_count(phy_req)) begin
        phy_req++;
        phy_word = 0;
      end
    end
    if (phy_req < NumReqs) begin
      if (phy_take || !phy_valid_i) begin
        phy_valid_i = ($random(seed) & 3) != 0;
      end
      a           = start_addr(phy_req) + burst_addr_t'(2 * phy_word);
      phy_data_i  = {mem_byte[phy_req][a + 8'd1], mem_byte[phy_req][a]};
      phy_error_i = mem_err[phy_req][a];
      phy_last_i  = (phy_word == word_count(phy_req) - 1);
    end else begin
      phy_valid_i = 1'b0;
    end
    phy_take = phy_valid_i && phy_ready_o;
  endtask

  always @(negedge clk_i) begin
    if (running) begin
      cycles++;
      if (cycles > TimeoutCycles) begin
        $display("ERROR: run hung waiting for R beats, %0d of %0d bursts done",
          chk_req, NumReqs);
        stop_on_error();
      end else begin
        drive_request();
        drive_phy();
        r_ready_i = ($random(seed) & 3) != 0;
        if (r_valid_o && r_ready_i) begin
          check_beat();
        end
      end
    end
  end

  initial begin
    seed         = 32'h9b8c_051a;
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    req_valid_i  = 1'b0;
    req_offset_i = '0;
    req_size_i   = '0;
    req_len_i    = '0;
    phy_valid_i  = 1'b0;
    phy_data_i   = '0;
    phy_last_i   = 1'b0;
    phy_error_i  = 1'b0;
    r_ready_i    = 1'b0;
    req_idx      = 0;
    phy_req      = 0;
    phy_word     = 0;
    chk_req      = 0;
    chk_beat     = 0;
    cycles       = 0;
    req_take     = 1'b0;
    phy_take     = 1'b0;
    queue_filled = 1'b0;
    running      = 1'b0;
    build_model();
    chk_addr = burst_addr_t'(req_offset[0]);
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    check_flag("r_valid_o", r_valid_o, 1'b0);
    check_flag("phy_ready_o", phy_ready_o, 1'b0);
    check_flag("req_ready_o", req_ready_o, 1'b1);
    rst_ni = 1'b1;
    @(posedge clk_i);
    running = 1'b1;
    wait (chk_req == NumReqs);
    // idle cycles to catch a stray extra beat
    repeat (20) @(posedge clk_i);
    if (queue_filled) begin
      $display("Testbench passed");
      $finish;
    end else begin
      $display("ERROR: req_ready_o never dropped, the request queue was never full");
      stop_on_error();
    end
  end

endmodule

`default_nettype wire
